// ==== include/csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN 64

// machine mode csrs
`define CSR_MSTATUS  12'h300
`define CSR_MEDELEG  12'h302
`define CSR_MIDELEG  12'h303
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344

// supervisor mode csrs
`define CSR_SSTATUS  12'h100
`define CSR_SIE      12'h104
`define CSR_STVEC    12'h105
`define CSR_SSCRATCH 12'h140
`define CSR_SEPC     12'h141
`define CSR_SCAUSE   12'h142
`define CSR_STVAL    12'h143
`define CSR_SIP      12'h144

// counters and their user aliases
`define CSR_MCYCLE   12'hb00
`define CSR_MINSTRET 12'hb02
`define CSR_CYCLE    12'hc00
`define CSR_INSTRET  12'hc02

// mstatus fields, mpp is 12:11
`define ST_SIE    1
`define ST_MIE    3
`define ST_SPIE   5
`define ST_MPIE   7
`define ST_SPP    8
`define ST_MPP_LO 11

// interrupt bits, same as the cause codes
`define IRQ_SSI 1
`define IRQ_MSI 3
`define IRQ_STI 5
`define IRQ_MTI 7
`define IRQ_SEI 9
`define IRQ_MEI 11

`define SIE_MASK     64'h0000_0000_0000_0222
`define MIE_MASK     64'h0000_0000_0000_0aaa
`define SSTATUS_MASK 64'h0000_0000_0000_0122

`endif

// ==== src/csr_pkg.sv ====
`include "csr_settings.svh"

package csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // encoding as in mstatus.mpp
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_t;

    // mcause / scause layout
    typedef struct packed {
        logic                   intr;
        logic [`CSR_XLEN-2:0]   code;
    } cause_t;

    // write port from writeback
    typedef struct packed {
        logic                   we;
        csr_addr_t              addr;
        logic [`CSR_XLEN-1:0]   wdata;
    } csr_wr_t;

endpackage

// ==== src/csr_trap_if.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

interface csr_trap_if;
    import csr_pkg::*;

    // one strobe at most per cycle, taken at the next edge
    logic                   m_trap;
    logic                   s_trap;
    logic                   m_ret;
    logic                   s_ret;

    // valid only with m_trap or s_trap
    logic [`CSR_XLEN-1:0]   epc;
    cause_t                 cause;
    logic [`CSR_XLEN-1:0]   tval;

    modport ctrl (
        output m_trap, s_trap, m_ret, s_ret, epc, cause, tval
    );

    modport state (
        input m_trap, s_trap, m_ret, s_ret, epc, cause, tval
    );

endinterface

// ==== src/csr_status.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_status (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_pkg::csr_wr_t        wr,
    csr_trap_if.state               trap,
    output csr_pkg::priv_t          priv,
    output logic [`CSR_XLEN-1:0]    mstatus
);
    import csr_pkg::*;

    logic [1:0] mpp;
    logic       spp;
    logic       mpie;
    logic       spie;
    logic       mie;
    logic       sie;
    logic       wr_mstatus;
    logic       wr_sstatus;

    assign wr_mstatus = wr.we && wr.addr == `CSR_MSTATUS;
    assign wr_sstatus = wr.we && wr.addr == `CSR_SSTATUS;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= PRIV_M;
            mpp  <= 2'b00;
            spp  <= 1'b0;
            mpie <= 1'b0;
            spie <= 1'b0;
            mie  <= 1'b0;
            sie  <= 1'b0;
        end else if (trap.m_trap) begin
            priv <= PRIV_M;
            mpie <= mie;
            mie  <= 1'b0;
            mpp  <= priv;
        end else if (trap.s_trap) begin
            priv <= PRIV_S;
            spie <= sie;
            sie  <= 1'b0;
            spp  <= (priv == PRIV_S);
        end else if (trap.m_ret) begin
            priv <= priv_t'(mpp);
            mie  <= mpie;
            mpie <= 1'b1;
            mpp  <= PRIV_U;
        end else if (trap.s_ret) begin
            priv <= priv_t'({1'b0, spp});
            sie  <= spie;
            spie <= 1'b1;
            spp  <= 1'b0;
        end else if (wr_mstatus) begin
            // mpp 2'b10 is reserved, old value kept
            if (wr.wdata[`ST_MPP_LO +: 2] != 2'b10) begin
                mpp <= wr.wdata[`ST_MPP_LO +: 2];
            end
            spp  <= wr.wdata[`ST_SPP];
            mpie <= wr.wdata[`ST_MPIE];
            spie <= wr.wdata[`ST_SPIE];
            mie  <= wr.wdata[`ST_MIE];
            sie  <= wr.wdata[`ST_SIE];
        end else if (wr_sstatus) begin
            spp  <= wr.wdata[`ST_SPP];
            spie <= wr.wdata[`ST_SPIE];
            sie  <= wr.wdata[`ST_SIE];
        end
    end

    always_comb begin
        mstatus                   = '0;
        mstatus[`ST_SIE]          = sie;
        mstatus[`ST_MIE]          = mie;
        mstatus[`ST_SPIE]         = spie;
        mstatus[`ST_MPIE]         = mpie;
        mstatus[`ST_SPP]          = spp;
        mstatus[`ST_MPP_LO +: 2]  = mpp;
    end

    a_priv_legal: assert property (@(posedge clk) disable iff (rst)
        priv inside {PRIV_U, PRIV_S, PRIV_M});

endmodule

// ==== src/csr_trap_state.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_state (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_pkg::csr_wr_t        wr,
    csr_trap_if.state               trap,
    input  logic                    time_int,
    output logic [`CSR_XLEN-1:0]    mepc,
    output logic [`CSR_XLEN-1:0]    sepc,
    output logic [`CSR_XLEN-1:0]    mcause,
    output logic [`CSR_XLEN-1:0]    scause,
    output logic [`CSR_XLEN-1:0]    mtval,
    output logic [`CSR_XLEN-1:0]    stval,
    output logic [`CSR_XLEN-1:0]    mtvec,
    output logic [`CSR_XLEN-1:0]    stvec,
    output logic [`CSR_XLEN-1:0]    mscratch,
    output logic [`CSR_XLEN-1:0]    sscratch,
    output logic [`CSR_XLEN-1:0]    medeleg,
    output logic [`CSR_XLEN-1:0]    mideleg,
    output logic [`CSR_XLEN-1:0]    mie,
    output logic [`CSR_XLEN-1:0]    mip
);
    import csr_pkg::*;

    // ssip, stip and seip only
    logic [`CSR_XLEN-1:0] sip_q;

    function automatic logic hit(input csr_addr_t addr);
        return wr.we && wr.addr == addr;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc     <= '0;
            sepc     <= '0;
            mcause   <= '0;
            scause   <= '0;
            mtval    <= '0;
            stval    <= '0;
            mtvec    <= '0;
            stvec    <= '0;
            mscratch <= '0;
            sscratch <= '0;
            medeleg  <= '0;
            mideleg  <= '0;
            mie      <= '0;
            sip_q    <= '0;
        end else begin
            if (trap.m_trap) begin
                mepc   <= trap.epc;
                mcause <= trap.cause;
                mtval  <= trap.tval;
            end else begin
                if (hit(`CSR_MEPC))   mepc   <= wr.wdata;
                if (hit(`CSR_MCAUSE)) mcause <= wr.wdata;
                if (hit(`CSR_MTVAL))  mtval  <= wr.wdata;
            end
            if (trap.s_trap) begin
                sepc   <= trap.epc;
                scause <= trap.cause;
                stval  <= trap.tval;
            end else begin
                if (hit(`CSR_SEPC))   sepc   <= wr.wdata;
                if (hit(`CSR_SCAUSE)) scause <= wr.wdata;
                if (hit(`CSR_STVAL))  stval  <= wr.wdata;
            end
            if (hit(`CSR_MTVEC))    mtvec    <= wr.wdata;
            if (hit(`CSR_STVEC))    stvec    <= wr.wdata;
            if (hit(`CSR_MSCRATCH)) mscratch <= wr.wdata;
            if (hit(`CSR_SSCRATCH)) sscratch <= wr.wdata;
            if (hit(`CSR_MEDELEG))  medeleg  <= wr.wdata;
            // only supervisor interrupts can be delegated
            if (hit(`CSR_MIDELEG))  mideleg  <= wr.wdata & `SIE_MASK;
            if (hit(`CSR_MIE)) begin
                mie <= wr.wdata & `MIE_MASK;
            end else if (hit(`CSR_SIE)) begin
                mie <= (mie & ~`SIE_MASK) | (wr.wdata & `SIE_MASK);
            end
            if (hit(`CSR_MIP) || hit(`CSR_SIP)) begin
                sip_q <= wr.wdata & `SIE_MASK;
            end
        end
    end

    // mtip straight from the timer, msip and meip tied low
    always_comb begin
        mip           = sip_q;
        mip[`IRQ_MTI] = time_int;
    end

endmodule

// ==== src/csr_trap_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_ctrl (
    input  csr_pkg::priv_t          priv,
    input  logic [`CSR_XLEN-1:0]    mstatus,
    input  logic [`CSR_XLEN-1:0]    mie,
    input  logic [`CSR_XLEN-1:0]    mip,
    input  logic [`CSR_XLEN-1:0]    mideleg,
    input  logic [`CSR_XLEN-1:0]    medeleg,
    input  logic [`CSR_XLEN-1:0]    mtvec,
    input  logic [`CSR_XLEN-1:0]    stvec,
    input  logic [`CSR_XLEN-1:0]    mepc,
    input  logic [`CSR_XLEN-1:0]    sepc,
    input  logic [`CSR_XLEN-1:0]    pc_wb,
    input  logic                    valid_wb,
    input  logic                    except_valid,
    input  logic [`CSR_XLEN-1:0]    except_cause,
    input  logic [`CSR_XLEN-1:0]    except_tval,
    input  logic [1:0]              ret_wb,
    csr_trap_if.ctrl                trap,
    output logic                    switch_mode,
    output logic [`CSR_XLEN-1:0]    pc_csr
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0]   pending;
    logic [`CSR_XLEN-1:0]   en_m;
    logic [`CSR_XLEN-1:0]   en_s;
    logic [`CSR_XLEN-1:0]   en_all;
    logic                   m_ok;
    logic                   s_ok;
    logic                   interrupt;
    logic [5:0]             irq_code;
    cause_t                 int_cause;
    logic                   s_int;
    logic                   s_exc;
    logic                   m_trap;
    logic                   s_trap;
    logic                   m_ret;
    logic                   s_ret;

    assign pending = mie & mip;
    assign m_ok    = (priv == PRIV_M && mstatus[`ST_MIE]) || priv != PRIV_M;
    assign s_ok    = (priv == PRIV_S && mstatus[`ST_SIE]) || priv == PRIV_U;
    assign en_m    = pending & ~mideleg & {`CSR_XLEN{m_ok}};
    assign en_s    = pending & mideleg & {`CSR_XLEN{s_ok}};
    assign en_all  = en_m | en_s;
    assign interrupt = |en_all;

    // fixed order: MEI MSI MTI SEI SSI STI
    always_comb begin
        irq_code = '0;
        if (en_all[`IRQ_MEI])      irq_code = 6'(`IRQ_MEI);
        else if (en_all[`IRQ_MSI]) irq_code = 6'(`IRQ_MSI);
        else if (en_all[`IRQ_MTI]) irq_code = 6'(`IRQ_MTI);
        else if (en_all[`IRQ_SEI]) irq_code = 6'(`IRQ_SEI);
        else if (en_all[`IRQ_SSI]) irq_code = 6'(`IRQ_SSI);
        else if (en_all[`IRQ_STI]) irq_code = 6'(`IRQ_STI);
    end

    assign int_cause.intr = 1'b1;
    assign int_cause.code = {{(`CSR_XLEN-7){1'b0}}, irq_code};

    assign s_int  = en_s[irq_code] && valid_wb;
    assign s_exc  = !interrupt && except_valid && medeleg[except_cause[5:0]];
    assign s_trap = (s_int || s_exc) && priv == PRIV_S;
    assign m_trap = ((interrupt && valid_wb) || except_valid) && !s_trap;
    // mret wins if both return bits are set
    assign m_ret  = ret_wb[1] && !m_trap && !s_trap;
    assign s_ret  = ret_wb[0] && !ret_wb[1] && !m_trap && !s_trap;

    assign trap.m_trap = m_trap;
    assign trap.s_trap = s_trap;
    assign trap.m_ret  = m_ret;
    assign trap.s_ret  = s_ret;
    assign trap.epc    = pc_wb;
    assign trap.cause  = interrupt ? int_cause : cause_t'(except_cause);
    assign trap.tval   = interrupt ? '0 : except_tval;

    assign switch_mode = m_trap || s_trap || m_ret || s_ret;
    assign pc_csr = m_trap ? mtvec :
                    s_trap ? stvec :
                    m_ret  ? mepc  :
                    s_ret  ? sepc  : '0;

endmodule

// ==== src/csr_counters.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_counters (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_pkg::csr_wr_t        wr,
    input  logic                    valid_wb,
    input  logic                    switch_mode,
    output logic [`CSR_XLEN-1:0]    mcycle,
    output logic [`CSR_XLEN-1:0]    minstret
);
    import csr_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (wr.we && wr.addr == `CSR_MCYCLE) begin
                mcycle <= wr.wdata;
            end else begin
                mcycle <= mcycle + `CSR_XLEN'(1);
            end
            // trapped or returning instructions do not retire
            if (wr.we && wr.addr == `CSR_MINSTRET) begin
                minstret <= wr.wdata;
            end else if (valid_wb && !switch_mode) begin
                minstret <= minstret + `CSR_XLEN'(1);
            end
        end
    end

endmodule

// ==== src/csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_t      raddr,
    input  logic [`CSR_XLEN-1:0]    mstatus,
    input  logic [`CSR_XLEN-1:0]    mepc,
    input  logic [`CSR_XLEN-1:0]    sepc,
    input  logic [`CSR_XLEN-1:0]    mcause,
    input  logic [`CSR_XLEN-1:0]    scause,
    input  logic [`CSR_XLEN-1:0]    mtval,
    input  logic [`CSR_XLEN-1:0]    stval,
    input  logic [`CSR_XLEN-1:0]    mtvec,
    input  logic [`CSR_XLEN-1:0]    stvec,
    input  logic [`CSR_XLEN-1:0]    mscratch,
    input  logic [`CSR_XLEN-1:0]    sscratch,
    input  logic [`CSR_XLEN-1:0]    medeleg,
    input  logic [`CSR_XLEN-1:0]    mideleg,
    input  logic [`CSR_XLEN-1:0]    mie,
    input  logic [`CSR_XLEN-1:0]    mip,
    input  logic [`CSR_XLEN-1:0]    mcycle,
    input  logic [`CSR_XLEN-1:0]    minstret,
    output logic [`CSR_XLEN-1:0]    rdata
);
    import csr_pkg::*;

    always_comb begin
        case (raddr)
            `CSR_MSTATUS:  rdata = mstatus;
            `CSR_MEDELEG:  rdata = medeleg;
            `CSR_MIDELEG:  rdata = mideleg;
            `CSR_MIE:      rdata = mie;
            `CSR_MTVEC:    rdata = mtvec;
            `CSR_MSCRATCH: rdata = mscratch;
            `CSR_MEPC:     rdata = mepc;
            `CSR_MCAUSE:   rdata = mcause;
            `CSR_MTVAL:    rdata = mtval;
            `CSR_MIP:      rdata = mip;
            // supervisor views of the machine registers
            `CSR_SSTATUS:  rdata = mstatus & `SSTATUS_MASK;
            `CSR_SIE:      rdata = mie & `SIE_MASK;
            `CSR_SIP:      rdata = mip & `SIE_MASK;
            `CSR_STVEC:    rdata = stvec;
            `CSR_SSCRATCH: rdata = sscratch;
            `CSR_SEPC:     rdata = sepc;
            `CSR_SCAUSE:   rdata = scause;
            `CSR_STVAL:    rdata = stval;
            `CSR_MCYCLE,
            `CSR_CYCLE:    rdata = mcycle;
            `CSR_MINSTRET,
            `CSR_INSTRET:  rdata = minstret;
            default:       rdata = '0;
        endcase
    end

endmodule

// ==== src/csr_top.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    csr_we,
    input  logic [11:0]             csr_waddr,
    input  logic [`CSR_XLEN-1:0]    csr_wdata,
    input  logic [11:0]             csr_raddr,
    output logic [`CSR_XLEN-1:0]    csr_rdata,
    input  logic [`CSR_XLEN-1:0]    pc_wb,
    input  logic                    valid_wb,
    input  logic                    except_valid,
    input  logic [`CSR_XLEN-1:0]    except_cause,
    input  logic [`CSR_XLEN-1:0]    except_tval,
    input  logic [1:0]              ret_wb,
    input  logic                    time_int,
    output logic [1:0]              priv,
    output logic                    switch_mode,
    output logic [`CSR_XLEN-1:0]    pc_csr
);
    import csr_pkg::*;

    csr_wr_t                wr;
    priv_t                  cur_priv;
    logic [`CSR_XLEN-1:0]   mstatus;
    logic [`CSR_XLEN-1:0]   mepc, sepc, mcause, scause, mtval, stval;
    logic [`CSR_XLEN-1:0]   mtvec, stvec, mscratch, sscratch;
    logic [`CSR_XLEN-1:0]   medeleg, mideleg, mie, mip;
    logic [`CSR_XLEN-1:0]   mcycle, minstret;

    csr_trap_if trap_bus ();

    assign wr.we    = csr_we;
    assign wr.addr  = csr_waddr;
    assign wr.wdata = csr_wdata;
    assign priv     = cur_priv;

    csr_status u_status (
        .clk, .rst, .wr, .trap(trap_bus.state), .priv(cur_priv), .mstatus
    );

    csr_trap_state u_trap_state (
        .clk, .rst, .wr, .trap(trap_bus.state), .time_int,
        .mepc, .sepc, .mcause, .scause, .mtval, .stval, .mtvec, .stvec,
        .mscratch, .sscratch, .medeleg, .mideleg, .mie, .mip
    );

    csr_trap_ctrl u_trap_ctrl (
        .priv(cur_priv), .mstatus, .mie, .mip, .mideleg, .medeleg,
        .mtvec, .stvec, .mepc, .sepc,
        .pc_wb, .valid_wb, .except_valid, .except_cause, .except_tval, .ret_wb,
        .trap(trap_bus.ctrl), .switch_mode, .pc_csr
    );

    csr_counters u_counters (
        .clk, .rst, .wr, .valid_wb, .switch_mode, .mcycle, .minstret
    );

    csr_read_mux u_read_mux (
        .raddr(csr_raddr), .mstatus, .mepc, .sepc, .mcause, .scause,
        .mtval, .stval, .mtvec, .stvec, .mscratch, .sscratch,
        .medeleg, .mideleg, .mie, .mip, .mcycle, .minstret,
        .rdata(csr_rdata)
    );

endmodule

// ==== tests/csr_checker.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    csr_we,
    input  logic [11:0]             csr_waddr,
    input  logic [`CSR_XLEN-1:0]    csr_wdata,
    input  logic [11:0]             csr_raddr,
    input  logic [`CSR_XLEN-1:0]    csr_rdata,
    input  logic [`CSR_XLEN-1:0]    pc_wb,
    input  logic                    valid_wb,
    input  logic                    except_valid,
    input  logic [`CSR_XLEN-1:0]    except_cause,
    input  logic [`CSR_XLEN-1:0]    except_tval,
    input  logic [1:0]              ret_wb,
    input  logic                    time_int,
    input  logic [1:0]              priv,
    input  logic                    switch_mode,
    input  logic [`CSR_XLEN-1:0]    pc_csr,
    input  int                      test_num,
    input  logic                    test_end,
    output int                      err_count,
    output int                      check_count
);
    // reference state
    logic [1:0]  r_priv;
    logic        sie_b, mie_b, spie, mpie, spp;
    logic [1:0]  mpp;
    logic [63:0] mepc, sepc, mcause, scause, mtval, stval;
    logic [63:0] mtvec, stvec, mscratch, sscratch, medeleg, mideleg, mie_r, sip_q;
    logic [63:0] mcyc, minst;
    int          test_errs;
    logic        mt, st, mr, sr;
    logic [63:0] t_cause, t_tval, t_target;

    initial begin
        err_count   = 0;
        check_count = 0;
        test_errs   = 0;
    end

    function automatic string test_name(input int n);
        case (n)
            1: return "reset values";
            2: return "write and read-back";
            3: return "machine exception and mret";
            4: return "delegated exception and sret";
            5: return "timer interrupt";
            6: return "counters";
            default: return "unnamed";
        endcase
    endfunction

    function automatic logic [63:0] status_ref();
        logic [63:0] s;
        s = '0;
        s[1] = sie_b;
        s[3] = mie_b;
        s[5] = spie;
        s[7] = mpie;
        s[8] = spp;
        s[12:11] = mpp;
        return s;
    endfunction

    function automatic logic [63:0] mip_ref();
        return sip_q | ({63'b0, time_int} << 7);
    endfunction

    function automatic logic [63:0] read_ref(input logic [11:0] a);
        case (a)
            `CSR_MSTATUS:  return status_ref();
            `CSR_SSTATUS:  return status_ref() & 64'h122;
            `CSR_MEDELEG:  return medeleg;
            `CSR_MIDELEG:  return mideleg;
            `CSR_MIE:      return mie_r;
            `CSR_SIE:      return mie_r & 64'h222;
            `CSR_MIP:      return mip_ref();
            `CSR_SIP:      return mip_ref() & 64'h222;
            `CSR_MTVEC:    return mtvec;
            `CSR_STVEC:    return stvec;
            `CSR_MSCRATCH: return mscratch;
            `CSR_SSCRATCH: return sscratch;
            `CSR_MEPC:     return mepc;
            `CSR_SEPC:     return sepc;
            `CSR_MCAUSE:   return mcause;
            `CSR_SCAUSE:   return scause;
            `CSR_MTVAL:    return mtval;
            `CSR_STVAL:    return stval;
            `CSR_MCYCLE, `CSR_CYCLE:     return mcyc;
            `CSR_MINSTRET, `CSR_INSTRET: return minst;
            default:       return '0;
        endcase
    endfunction

    // expected trap or return decision for the current inputs
    function automatic void decide(output logic o_mt, o_st, o_mr, o_sr,
                                   output logic [63:0] o_cause, o_tval, o_target);
        int          order [6];
        logic [63:0] pend;
        logic [63:0] en;
        logic        m_ok, s_ok, irq, deleg;
        int          code;
        order = '{11, 3, 7, 9, 1, 5};
        pend  = mie_r & mip_ref();
        m_ok  = (r_priv != 2'b11) || mie_b;
        s_ok  = (r_priv == 2'b01 && sie_b) || r_priv == 2'b00;
        en    = (pend & ~mideleg & {64{m_ok}}) | (pend & mideleg & {64{s_ok}});
        irq   = 1'b0;
        code  = 0;
        for (int i = 0; i < 6; i++) begin
            if (!irq && en[order[i]]) begin
                irq  = 1'b1;
                code = order[i];
            end
        end
        deleg = irq ? mideleg[code] : (except_valid && medeleg[except_cause[5:0]]);
        o_st = r_priv == 2'b01 && ((irq && deleg && valid_wb) || (!irq && deleg));
        o_mt = !o_st && ((irq && valid_wb) || except_valid);
        o_mr = !o_mt && !o_st && ret_wb[1];
        o_sr = !o_mt && !o_st && !ret_wb[1] && ret_wb[0];
        o_cause  = irq ? ({1'b1, 63'b0} | 64'(code)) : except_cause;
        o_tval   = irq ? '0 : except_tval;
        o_target = o_mt ? mtvec : o_st ? stvec : o_mr ? mepc : o_sr ? sepc : '0;
    endfunction

    task automatic reset_model();
        r_priv = 2'b11;
        {sie_b, mie_b, spie, mpie, spp, mpp} = '0;
        {mepc, sepc, mcause, scause, mtval, stval} = '0;
        {mtvec, stvec, mscratch, sscratch, medeleg, mideleg, mie_r, sip_q} = '0;
        mcyc  = '0;
        minst = '0;
    endtask

    task automatic update_model();
        logic any;
        any = mt | st | mr | sr;
        mcyc  = (csr_we && csr_waddr == `CSR_MCYCLE) ? csr_wdata : mcyc + 1;
        if (csr_we && csr_waddr == `CSR_MINSTRET) minst = csr_wdata;
        else if (valid_wb && !any) minst = minst + 1;
        if (csr_we) begin
            case (csr_waddr)
                `CSR_MSTATUS: if (!any) begin
                    if (csr_wdata[12:11] != 2'b10) mpp = csr_wdata[12:11];
                    {spp, mpie, spie, mie_b, sie_b} =
                        {csr_wdata[8], csr_wdata[7], csr_wdata[5], csr_wdata[3], csr_wdata[1]};
                end
                `CSR_SSTATUS: if (!any) begin
                    {spp, spie, sie_b} = {csr_wdata[8], csr_wdata[5], csr_wdata[1]};
                end
                `CSR_MEPC:     mepc = csr_wdata;
                `CSR_SEPC:     sepc = csr_wdata;
                `CSR_MCAUSE:   mcause = csr_wdata;
                `CSR_SCAUSE:   scause = csr_wdata;
                `CSR_MTVAL:    mtval = csr_wdata;
                `CSR_STVAL:    stval = csr_wdata;
                `CSR_MTVEC:    mtvec = csr_wdata;
                `CSR_STVEC:    stvec = csr_wdata;
                `CSR_MSCRATCH: mscratch = csr_wdata;
                `CSR_SSCRATCH: sscratch = csr_wdata;
                `CSR_MEDELEG:  medeleg = csr_wdata;
                `CSR_MIDELEG:  mideleg = csr_wdata & 64'h222;
                `CSR_MIE:      mie_r = csr_wdata & 64'haaa;
                `CSR_SIE:      mie_r = (mie_r & ~64'h222) | (csr_wdata & 64'h222);
                `CSR_MIP, `CSR_SIP: sip_q = csr_wdata & 64'h222;
                default: ;
            endcase
        end
        if (mt) begin
            {mpie, mie_b, mpp, r_priv} = {mie_b, 1'b0, r_priv, 2'b11};
            {mepc, mcause, mtval} = {pc_wb, t_cause, t_tval};
        end else if (st) begin
            {spie, sie_b, spp, r_priv} = {sie_b, 1'b0, r_priv == 2'b01, 2'b01};
            {sepc, scause, stval} = {pc_wb, t_cause, t_tval};
        end else if (mr) begin
            {r_priv, mie_b, mpie, mpp} = {mpp, mpie, 1'b1, 2'b00};
        end else if (sr) begin
            {r_priv, sie_b, spie, spp} = {1'b0, spp, spie, 1'b1, 1'b0};
        end
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            test_errs++;
            $display("CHECK FAILED %s: got %h, expected %h (test %0d)", name, got, exp, test_num);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            decide(mt, st, mr, sr, t_cause, t_tval, t_target);
            check("csr_rdata", csr_rdata, read_ref(csr_raddr));
            check("switch_mode", {63'b0, switch_mode}, {63'b0, mt | st | mr | sr});
            check("pc_csr", pc_csr, t_target);
            check("priv", {62'b0, priv}, {62'b0, r_priv});
            update_model();
        end
        if (test_end) begin
            $display("test %0d %s: %s, %0d errors", test_num, test_name(test_num),
                     test_errs == 0 ? "ok" : "failed", test_errs);
            test_errs = 0;
        end
    end

endmodule

// ==== tests/tb_csr.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr;
    localparam int STIM_CYCLES = 300;

    logic        clk, rst, csr_we, valid_wb, except_valid, time_int, switch_mode, test_end;
    logic [11:0] csr_waddr, csr_raddr;
    logic [63:0] csr_wdata, csr_rdata, pc_wb, except_cause, except_tval, pc_csr;
    logic [1:0]  ret_wb, priv;
    logic [31:0] rng;
    logic [63:0] v;
    logic [11:0] addr_list [$];
    int          test_num, err_count, check_count;

    csr_top u_dut (
        .clk, .rst, .csr_we, .csr_waddr, .csr_wdata, .csr_raddr, .csr_rdata,
        .pc_wb, .valid_wb, .except_valid, .except_cause, .except_tval, .ret_wb,
        .time_int, .priv, .switch_mode, .pc_csr
    );

    csr_checker u_checker (
        .clk, .rst, .csr_we, .csr_waddr, .csr_wdata, .csr_raddr, .csr_rdata,
        .pc_wb, .valid_wb, .except_valid, .except_cause, .except_tval, .ret_wb,
        .time_int, .priv, .switch_mode, .pc_csr, .test_num, .test_end,
        .err_count, .check_count
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_rand(output logic [63:0] r);
        rng = xorshift(rng);
        r[63:32] = rng;
        rng = xorshift(rng);
        r[31:0] = rng;
    endtask

    // each operation holds its inputs for one cycle
    task automatic clear_inputs();
        csr_we = 0;
        valid_wb = 0;
        except_valid = 0;
        ret_wb = 2'b00;
    endtask

    task automatic write_csr(input logic [11:0] a, input logic [63:0] d);
        @(negedge clk);
        clear_inputs();
        {csr_we, csr_waddr, csr_wdata} = {1'b1, a, d};
    endtask

    task automatic read_csr(input logic [11:0] a);
        @(negedge clk);
        clear_inputs();
        csr_raddr = a;
    endtask

    task automatic commit(input logic exc, input logic [63:0] cause, input logic [1:0] ret);
        @(negedge clk);
        clear_inputs();
        next_rand(pc_wb);
        next_rand(except_tval);
        {valid_wb, except_valid, except_cause, ret_wb} = {1'b1, exc, cause, ret};
    endtask

    task automatic end_test();
        @(negedge clk);
        clear_inputs();
        test_end = 1;
        @(negedge clk);
        test_end = 0;
        test_num++;
    endtask

    initial begin
        {clk, csr_we, valid_wb, except_valid, time_int, test_end} = '0;
        {csr_waddr, csr_raddr, csr_wdata, pc_wb, except_cause, except_tval} = '0;
        ret_wb = 2'b00;
        rst = 1;
        rng = 32'hb978;
        test_num = 1;
        addr_list = '{`CSR_MSTATUS, `CSR_MEDELEG, `CSR_MIDELEG, `CSR_MIE, `CSR_MTVEC,
                      `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP,
                      `CSR_SSTATUS, `CSR_SIE, `CSR_STVEC, `CSR_SSCRATCH, `CSR_SEPC,
                      `CSR_SCAUSE, `CSR_STVAL, `CSR_SIP, `CSR_MCYCLE, `CSR_MINSTRET};
        repeat (4) @(negedge clk);
        rst = 0;
        foreach (addr_list[i]) read_csr(addr_list[i]);
        end_test();
        // random values, then read back next cycle
        for (int i = 0; i < 18; i++) begin
            next_rand(v);
            write_csr(addr_list[i], v);
            read_csr(addr_list[i]);
            read_csr(`CSR_MSTATUS);
        end
        foreach (addr_list[i]) if (i < 18) write_csr(addr_list[i], '0);
        end_test();
        next_rand(v);
        write_csr(`CSR_MTVEC, v);
        commit(1, 64'd2, 2'b00);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MTVAL);
        read_csr(`CSR_MSTATUS);
        commit(0, '0, 2'b10);
        read_csr(`CSR_MSTATUS);
        end_test();
        next_rand(v);
        write_csr(`CSR_STVEC, v);
        write_csr(`CSR_MEDELEG, 64'h1 << 13);
        write_csr(`CSR_MSTATUS, 64'h800);
        commit(0, '0, 2'b10);
        commit(1, 64'd13, 2'b00);
        read_csr(`CSR_SEPC);
        read_csr(`CSR_SCAUSE);
        read_csr(`CSR_STVAL);
        read_csr(`CSR_SSTATUS);
        commit(0, '0, 2'b01);
        commit(1, 64'd2, 2'b00);
        read_csr(`CSR_MSTATUS);
        end_test();
        write_csr(`CSR_MIE, 64'h80);
        write_csr(`CSR_MSTATUS, 64'h8);
        read_csr(`CSR_MIP);
        time_int = 1;
        repeat (3) read_csr(`CSR_MIP);
        commit(0, '0, 2'b00);
        read_csr(`CSR_MCAUSE);
        time_int = 0;
        read_csr(`CSR_MTVAL);
        commit(0, '0, 2'b10);
        write_csr(`CSR_MSTATUS, '0);
        time_int = 1;
        repeat (3) commit(0, '0, 2'b00);
        read_csr(`CSR_MINSTRET);
        time_int = 0;
        end_test();
        read_csr(`CSR_MCYCLE);
        repeat (5) read_csr(`CSR_CYCLE);
        repeat (3) commit(0, '0, 2'b00);
        read_csr(`CSR_INSTRET);
        next_rand(v);
        write_csr(`CSR_MCYCLE, v);
        read_csr(`CSR_MCYCLE);
        read_csr(`CSR_MINSTRET);
        end_test();
        repeat (2) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", test_num - 1, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(STIM_CYCLES * 8 + 200);
        $display("timeout: stimulus did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== csr.f ====
+incdir+include
src/csr_pkg.sv
src/csr_trap_if.sv
src/csr_status.sv
src/csr_trap_state.sv
src/csr_trap_ctrl.sv
src/csr_counters.sv
src/csr_read_mux.sv
src/csr_top.sv
tests/csr_checker.sv
tests/tb_csr.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_csr -f csr.f -o sim_csr > build.log 2>&1 \
    && ./obj_dir/sim_csr > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '^>>> FAIL' sim.log && exit 1 || exit 0
